// File: design/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Byte offset within a line
// 32-byte lines, the adapter assumes four 64-bit beats
`define CACHE_S_OFFSET 5

// Set index bits, 8 sets
`define CACHE_S_INDEX 3

// log2 of the associativity
// 1 for 2 ways, 2 for 4 ways
`define CACHE_WAY_DEG 1

// Number of ways
`define CACHE_WAYS (1 << `CACHE_WAY_DEG)

`endif

// File: design/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

    // Plain vector types for the cache widths
    typedef logic [31:0] cache_addr_t;
    typedef logic [31:0] cache_word_t;
    typedef logic [3:0] cache_be_t;
    typedef logic [255:0] cache_line_t;
    typedef logic [31-`CACHE_S_OFFSET-`CACHE_S_INDEX:0] cache_tag_t;
    typedef logic [`CACHE_S_INDEX-1:0] cache_index_t;
    typedef logic [`CACHE_WAY_DEG-1:0] cache_way_t;
    typedef logic [`CACHE_WAYS-1:0] cache_ways_t;
    // N ways need N-1 tree bits
    typedef logic [`CACHE_WAYS-2:0] cache_plru_t;
    typedef logic [63:0] mem_beat_t;

    // Line write source: fill from memory or merged CPU word
    typedef enum logic [0:0] {ca_rdata, cpu_wdata} datamux_sel_t;

    // Burst address source: requested line or evicted line
    typedef enum logic [0:0] {cpu_addr, victim_addr} addrmux_sel_t;

    // Strobes from the controller to tag and data arrays
    typedef struct packed {
        cache_ways_t load_tag;
        cache_ways_t set_valid;
        cache_ways_t load_dirty;
        cache_ways_t dirty_in;
        cache_ways_t load_data;
        logic load_lru;
        cache_plru_t lru_in;
        datamux_sel_t datamux_sel;
        addrmux_sel_t addrmux_sel;
    } cache_ctrl_t;

    // Lookup result of the indexed set
    typedef struct packed {
        logic hit;
        cache_way_t hit_way;
        cache_way_t lru_way;
        logic lru_dirty;
        cache_plru_t lru_out;
    } cache_status_t;

endpackage

// File: design/cache_control.sv
`timescale 1ns/1ns
`include "cache_settings.svh"

module cache_control
    import cache_pkg::*;
(
    input logic clk,
    input logic rst,

    // CPU request levels
    input logic mem_read,
    input logic mem_write,
    output logic mem_resp,

    // Lookup status from the tag array
    input cache_status_t status,

    // Line requests to the burst adapter
    input logic ca_resp,
    output logic ca_read,
    output logic ca_write,

    // Strobes to both arrays
    output cache_ctrl_t ctrl
);

    // Match also serves as idle, a hit answers in the same cycle
    typedef enum logic [1:0] {
        st_match,
        st_writeback,
        st_load
    } state_t;

    state_t state;
    state_t next_state;
    logic req;
    cache_plru_t lru_next;

    assign req = mem_read | mem_write;

    // PLRU bits after an access to the hit way
    generate
        if (`CACHE_WAY_DEG == 1) begin : g_plru2
            // Point at the other way
            assign lru_next = ~status.hit_way;
        end else begin : g_plru4
            always_comb begin
                // Root points at the other half
                lru_next[0] = ~status.hit_way[1];
                // Leaf of the used half points at its other way
                lru_next[1] = status.hit_way[1] ? status.lru_out[1] : ~status.hit_way[0];
                lru_next[2] = status.hit_way[1] ? ~status.hit_way[0] : status.lru_out[2];
            end
        end
    endgenerate

    always_comb begin
        next_state = state;
        case (state)
            st_match: begin
                // Dirty victim goes out before the fill
                if (req && !status.hit) begin
                    next_state = status.lru_dirty ? st_writeback : st_load;
                end
            end
            st_writeback: begin
                if (ca_resp) begin
                    next_state = st_load;
                end
            end
            st_load: begin
                if (ca_resp) begin
                    next_state = st_match;
                end
            end
            default: next_state = st_match;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_match;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        // Idle defaults
        ctrl = '0;
        ctrl.lru_in = lru_next;
        ctrl.datamux_sel = ca_rdata;
        ctrl.addrmux_sel = cpu_addr;
        mem_resp = 1'b0;
        ca_read = 1'b0;
        ca_write = 1'b0;

        case (state)
            st_match: begin
                mem_resp = req & status.hit;
                // Every served access refreshes the PLRU tree
                ctrl.load_lru = req & status.hit;
                // Write hit merges the word and marks the way dirty
                ctrl.datamux_sel = cpu_wdata;
                ctrl.dirty_in[status.hit_way] = 1'b1;
                ctrl.load_dirty[status.hit_way] = mem_write & status.hit;
                ctrl.load_data[status.hit_way] = mem_write & status.hit;
            end
            st_writeback: begin
                // Victim address and line go to the adapter
                ca_write = 1'b1;
                ctrl.addrmux_sel = victim_addr;
            end
            st_load: begin
                ca_read = 1'b1;
                // Fill lands on the edge of ca_resp, the line comes back clean
                ctrl.load_data[status.lru_way] = ca_resp;
                ctrl.load_tag[status.lru_way] = ca_resp;
                ctrl.set_valid[status.lru_way] = ca_resp;
                ctrl.load_dirty[status.lru_way] = ca_resp;
                ctrl.dirty_in[status.lru_way] = 1'b0;
            end
            default: ;
        endcase
    end

endmodule

// File: design/cache_tag_array.sv
`timescale 1ns/1ns
`include "cache_settings.svh"

module cache_tag_array
    import cache_pkg::*;
(
    input logic clk,
    input logic rst,
    input cache_addr_t mem_addr,
    input cache_ctrl_t ctrl,
    output cache_status_t status,
    output cache_addr_t ca_addr
);

    localparam int S_OFFSET = `CACHE_S_OFFSET;
    localparam int S_INDEX = `CACHE_S_INDEX;
    localparam int S_TAG = 32 - S_OFFSET - S_INDEX;
    localparam int NUM_SETS = 1 << S_INDEX;
    localparam int WAYS = `CACHE_WAYS;

    // Per set and way state
    cache_tag_t tags [NUM_SETS][WAYS];
    cache_ways_t valid [NUM_SETS];
    cache_ways_t dirty [NUM_SETS];
    // Per set tree bits
    cache_plru_t plru [NUM_SETS];

    cache_tag_t tag;
    cache_index_t idx;
    cache_plru_t plru_cur;
    cache_way_t victim;

    // Address fields of the CPU request
    assign tag = mem_addr[31:32-S_TAG];
    assign idx = mem_addr[S_OFFSET +: S_INDEX];
    assign plru_cur = plru[idx];

    // Victim way from the tree bits
    generate
        if (`CACHE_WAY_DEG == 1) begin : g_victim2
            assign victim = plru_cur[0];
        end else begin : g_victim4
            // Root picks the half, the leaf of that half picks the way
            assign victim = {plru_cur[0], plru_cur[0] ? plru_cur[2] : plru_cur[1]};
        end
    endgenerate

    // Tag compare over all valid ways
    always_comb begin
        status.hit = 1'b0;
        status.hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid[idx][w] && tags[idx][w] == tag) begin
                status.hit = 1'b1;
                status.hit_way = cache_way_t'(w);
            end
        end
        status.lru_way = victim;
        status.lru_dirty = dirty[idx][victim];
        status.lru_out = plru_cur;
    end

    // Line address of the fill or of the evicted line
    always_comb begin
        if (ctrl.addrmux_sel == victim_addr) begin
            ca_addr = {tags[idx][victim], idx, {S_OFFSET{1'b0}}};
        end else begin
            ca_addr = {mem_addr[31:S_OFFSET], {S_OFFSET{1'b0}}};
        end
    end

    // Status bits of the indexed set
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
                plru[s] <= '0;
            end
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (ctrl.set_valid[w]) begin
                    valid[idx][w] <= 1'b1;
                end
                if (ctrl.load_dirty[w]) begin
                    dirty[idx][w] <= ctrl.dirty_in[w];
                end
            end
            if (ctrl.load_lru) begin
                plru[idx] <= ctrl.lru_in;
            end
        end
    end

    // Tags only change on a fill
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (ctrl.load_tag[w]) begin
                tags[idx][w] <= tag;
            end
        end
    end

endmodule

// File: design/cache_data_array.sv
`timescale 1ns/1ns
`include "cache_settings.svh"

module cache_data_array
    import cache_pkg::*;
(
    input logic clk,
    input cache_addr_t mem_addr,
    input cache_word_t mem_wdata,
    input cache_be_t mem_byte_enable,
    input cache_ctrl_t ctrl,
    input cache_way_t hit_way,
    input cache_way_t lru_way,
    input cache_line_t ca_rdata,
    output cache_word_t mem_rdata,
    output cache_line_t ca_wdata
);

    localparam int S_OFFSET = `CACHE_S_OFFSET;
    localparam int S_INDEX = `CACHE_S_INDEX;
    localparam int NUM_SETS = 1 << S_INDEX;
    localparam int WAYS = `CACHE_WAYS;
    // Word select bits within a line
    localparam int S_WORD = S_OFFSET - 2;

    cache_line_t lines [NUM_SETS][WAYS];

    cache_index_t idx;
    logic [S_WORD-1:0] word_sel;
    cache_line_t hit_line;
    cache_line_t merged;
    cache_line_t line_in;

    assign idx = mem_addr[S_OFFSET +: S_INDEX];
    assign word_sel = mem_addr[S_OFFSET-1:2];
    assign hit_line = lines[idx][hit_way];

    // Word of the hit way to the CPU
    assign mem_rdata = hit_line[word_sel*32 +: 32];

    // Victim line for write-back
    assign ca_wdata = lines[idx][lru_way];

    // Enabled bytes of the CPU word replace those of the hit line
    always_comb begin
        merged = hit_line;
        for (int b = 0; b < 4; b++) begin
            if (mem_byte_enable[b]) begin
                merged[word_sel*32 + b*8 +: 8] = mem_wdata[b*8 +: 8];
            end
        end
    end

    // Fill line or merged line
    assign line_in = (ctrl.datamux_sel == cpu_wdata) ? merged : ca_rdata;

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (ctrl.load_data[w]) begin
                lines[idx][w] <= line_in;
            end
        end
    end

endmodule

// File: design/cacheline_adapter.sv
`timescale 1ns/1ns
`include "cache_settings.svh"

module cacheline_adapter
    import cache_pkg::*;
(
    input logic clk,
    input logic rst,

    // Line side, toward the controller and arrays
    input logic ca_read,
    input logic ca_write,
    input cache_addr_t ca_addr,
    input cache_line_t ca_wdata,
    output cache_line_t ca_rdata,
    output logic ca_resp,

    // Beat side, toward memory
    input mem_beat_t pmem_rdata,
    input logic pmem_resp,
    output logic pmem_read,
    output logic pmem_write,
    output cache_addr_t pmem_addr,
    output mem_beat_t pmem_wdata
);

    localparam int S_OFFSET = `CACHE_S_OFFSET;

    // Beat number within the burst
    logic [1:0] beat;
    logic last_beat;
    // Read beats 0 to 2, beat 3 is taken straight from the bus
    mem_beat_t rd_beats [3];

    assign last_beat = (beat == 2'd3);

    // Levels pass through for the whole burst
    assign pmem_read = ca_read;
    assign pmem_write = ca_write;
    assign pmem_addr = {ca_addr[31:S_OFFSET], {S_OFFSET{1'b0}}};

    // Outgoing write beat
    assign pmem_wdata = ca_wdata[beat*64 +: 64];

    // Line done with the fourth beat
    assign ca_resp = pmem_resp & last_beat;
    assign ca_rdata = {pmem_rdata, rd_beats[2], rd_beats[1], rd_beats[0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            beat <= 2'd0;
        end else if (pmem_resp && (ca_read || ca_write)) begin
            // Back to beat 0 after the final beat
            if (last_beat) begin
                beat <= 2'd0;
            end else begin
                beat <= beat + 2'd1;
            end
        end
    end

    // Capture read beats as they arrive
    always_ff @(posedge clk) begin
        if (ca_read && pmem_resp && !last_beat) begin
            rd_beats[beat] <= pmem_rdata;
        end
    end

endmodule

// File: design/cache.sv
`timescale 1ns/1ns

module cache
    import cache_pkg::*;
(
    input logic clk,
    input logic rst,

    // CPU port
    input cache_addr_t mem_addr,
    input logic mem_read,
    input logic mem_write,
    input cache_word_t mem_wdata,
    input cache_be_t mem_byte_enable,
    output cache_word_t mem_rdata,
    output logic mem_resp,

    // Burst memory port
    output cache_addr_t pmem_addr,
    output logic pmem_read,
    output logic pmem_write,
    output mem_beat_t pmem_wdata,
    input mem_beat_t pmem_rdata,
    input logic pmem_resp
);

    cache_status_t status;
    cache_ctrl_t ctrl;

    // Line transfer between arrays and adapter
    logic ca_read;
    logic ca_write;
    logic ca_resp;
    cache_addr_t ca_addr;
    cache_line_t ca_rdata;
    cache_line_t ca_wdata;

    cache_control control_inst (
        .clk(clk), .rst(rst), .mem_read(mem_read), .mem_write(mem_write),
        .mem_resp(mem_resp), .status(status), .ca_resp(ca_resp),
        .ca_read(ca_read), .ca_write(ca_write), .ctrl(ctrl)
    );

    cache_tag_array tag_array_inst (
        .clk(clk), .rst(rst), .mem_addr(mem_addr), .ctrl(ctrl),
        .status(status), .ca_addr(ca_addr)
    );

    cache_data_array data_array_inst (
        .clk(clk), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_byte_enable(mem_byte_enable), .ctrl(ctrl),
        .hit_way(status.hit_way), .lru_way(status.lru_way),
        .ca_rdata(ca_rdata), .mem_rdata(mem_rdata), .ca_wdata(ca_wdata)
    );

    cacheline_adapter adapter_inst (
        .clk(clk), .rst(rst), .ca_read(ca_read), .ca_write(ca_write),
        .ca_addr(ca_addr), .ca_wdata(ca_wdata), .ca_rdata(ca_rdata),
        .ca_resp(ca_resp), .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp),
        .pmem_read(pmem_read), .pmem_write(pmem_write),
        .pmem_addr(pmem_addr), .pmem_wdata(pmem_wdata)
    );

endmodule

// File: test/cache_tb.sv
`timescale 1ns/1ns

module cache_tb
    import cache_pkg::*;
();

    localparam int N_RANDOM = 2000;
    // Directed requests and the final flush stay below this
    localparam int N_FIXED = 64;
    localparam int MAX_CYCLES = 200 * (N_RANDOM + N_FIXED);
    localparam int MEM_BYTES = 8192;

    logic clk;
    logic rst;
    cache_addr_t mem_addr;
    logic mem_read;
    logic mem_write;
    cache_word_t mem_wdata;
    cache_be_t mem_byte_enable;
    cache_word_t mem_rdata;
    logic mem_resp;
    cache_addr_t pmem_addr;
    logic pmem_read;
    logic pmem_write;
    mem_beat_t pmem_wdata;
    mem_beat_t pmem_rdata;
    logic pmem_resp;

    // Memory model bytes and the golden image of CPU writes
    logic [7:0] mem [MEM_BYTES];
    logic [7:0] golden [MEM_BYTES];

    // Bursts seen during the current request, kind is pmem_write
    logic burst_kind [$];
    cache_addr_t burst_addr [$];

    // Expected residency for 8 sets of 2 ways
    cache_tag_t res_tag [8][2];
    logic res_valid [8][2];
    logic res_dirty [8][2];
    logic res_victim [8];

    int word_errors = 0;
    int addr_errors = 0;
    int flag_errors = 0;
    int other_errors = 0;
    int issued = 0;
    int cycles = 0;

    cache cache_inst (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Pattern mixes low and high address bits
    function automatic logic [7:0] fill_byte(input logic [12:0] a);
        return a[7:0] * 8'd13 ^ {3'b000, a[12:8]} * 8'd7;
    endfunction

    // Golden word after applying a write under its byte enables
    function automatic cache_word_t ref_access(input logic is_write, input cache_addr_t addr,
            input cache_word_t wdata, input cache_be_t be);
        logic [12:0] base;
        cache_word_t word;
        base = {addr[12:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
            if (is_write && be[b]) begin
                golden[base + 13'(b)] = wdata[b*8 +: 8];
            end
            word[b*8 +: 8] = golden[base + 13'(b)];
        end
        return word;
    endfunction

    // 2-way PLRU, the way not used most recently is the victim
    function automatic void predict_residency(input cache_addr_t addr, input logic is_write,
            output logic hit, output logic wb, output cache_addr_t victim_addr);
        logic [2:0] s;
        logic w;
        s = addr[7:5];
        hit = 1'b0;
        w = res_victim[s];
        for (int i = 0; i < 2; i++) begin
            if (res_valid[s][1'(i)] && res_tag[s][1'(i)] == addr[31:8]) begin
                hit = 1'b1;
                w = 1'(i);
            end
        end
        wb = 1'b0;
        victim_addr = {res_tag[s][w], s, 5'b00000};
        if (!hit) begin
            wb = res_valid[s][w] & res_dirty[s][w];
            res_valid[s][w] = 1'b1;
            res_tag[s][w] = addr[31:8];
            res_dirty[s][w] = 1'b0;
        end
        if (is_write) begin
            res_dirty[s][w] = 1'b1;
        end
        res_victim[s] = ~w;
    endfunction

    // Little endian, beat 0 holds the lowest line bytes
    function automatic mem_beat_t read_beat(input logic [12:0] base, input int beat);
        mem_beat_t data;
        for (int i = 0; i < 8; i++) begin
            data[i*8 +: 8] = mem[base + 13'(beat * 8 + i)];
        end
        return data;
    endfunction

    task automatic write_beat(input logic [12:0] base, input int beat, input mem_beat_t data);
        for (int i = 0; i < 8; i++) begin
            mem[base + 13'(beat * 8 + i)] = data[i*8 +: 8];
        end
    endtask

    task automatic check_word(input string name, input cache_word_t got, input cache_word_t exp);
        if (got !== exp) begin
            $display("error %0t: %s got %h expected %h", $time, name, got, exp);
            word_errors++;
        end
    endtask

    task automatic check_addr(input string name, input cache_addr_t got, input cache_addr_t exp);
        if (got !== exp) begin
            $display("error %0t: %s got %h expected %h", $time, name, got, exp);
            addr_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %0t: %s got %b expected %b", $time, name, got, exp);
            flag_errors++;
        end
    endtask

    // Write-back of the victim first, then the fill of the requested line
    task automatic check_bursts(input logic hit, input logic wb, input cache_addr_t victim_addr,
            input cache_addr_t addr, input int wait_cycles);
        int n;
        n = hit ? 0 : (wb ? 2 : 1);
        if (burst_kind.size() != n) begin
            $display("request to %h made %0d bursts instead of %0d at %0t",
                addr, burst_kind.size(), n, $time);
            other_errors++;
        end else if (n > 0) begin
            if (wb) begin
                check_flag("pmem_write", burst_kind[0], 1'b1);
                check_addr("pmem_addr", burst_addr[0], victim_addr);
            end
            check_flag("pmem_write", burst_kind[n-1], 1'b0);
            check_addr("pmem_addr", burst_addr[n-1], {addr[31:5], 5'b00000});
        end
        if (hit && wait_cycles != 0) begin
            $display("hit on %h was answered %0d cycles late at %0t", addr, wait_cycles, $time);
            other_errors++;
        end
    endtask

    // One CPU request held until mem_resp
    task automatic cpu_access(input logic is_write, input cache_addr_t addr,
            input cache_word_t wdata, input cache_be_t be);
        logic hit;
        logic wb;
        cache_addr_t victim_addr;
        int wait_cycles;
        predict_residency(addr, is_write, hit, wb, victim_addr);
        burst_kind.delete();
        burst_addr.delete();
        issued++;
        @(posedge clk);
        mem_addr <= addr;
        mem_read <= !is_write;
        mem_write <= is_write;
        mem_wdata <= wdata;
        mem_byte_enable <= be;
        wait_cycles = 0;
        @(negedge clk);
        while (!mem_resp) begin
            wait_cycles++;
            @(negedge clk);
        end
        @(posedge clk);
        mem_read <= 1'b0;
        mem_write <= 1'b0;
        check_bursts(hit, wb, victim_addr, addr, wait_cycles);
    endtask

    task automatic compare_image(input int first, input int last);
        cache_word_t got;
        cache_word_t exp;
        for (int a = first; a < last; a += 4) begin
            for (int b = 0; b < 4; b++) begin
                got[b*8 +: 8] = mem[13'(a + b)];
                exp[b*8 +: 8] = golden[13'(a + b)];
            end
            check_word($sformatf("memory word %h", a), got, exp);
        end
    endtask

    // Every response is checked against the golden image
    always @(negedge clk) begin
        cache_word_t expected;
        if (!rst && mem_resp) begin
            expected = ref_access(mem_write, mem_addr, mem_wdata, mem_byte_enable);
            if (mem_read) begin
                check_word("mem_rdata", mem_rdata, expected);
            end
        end
    end

    // Burst memory, each beat answered after 1 to 4 cycles
    initial begin : memory_model
        logic is_write;
        cache_addr_t base;
        pmem_resp <= 1'b0;
        pmem_rdata <= '0;
        forever begin
            @(negedge clk);
            if (pmem_read || pmem_write) begin
                is_write = pmem_write;
                base = pmem_addr;
                burst_kind.push_back(is_write);
                burst_addr.push_back(base);
                for (int beat = 0; beat < 4; beat++) begin
                    repeat (1 + $urandom % 4) @(posedge clk);
                    pmem_resp <= 1'b1;
                    pmem_rdata <= read_beat(base[12:0], beat);
                    @(negedge clk);
                    // Levels stay up for the whole burst
                    check_flag("pmem_read", pmem_read, !is_write);
                    check_flag("pmem_write", pmem_write, is_write);
                    if (is_write) begin
                        write_beat(base[12:0], beat, pmem_wdata);
                    end
                    @(posedge clk);
                    pmem_resp <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the cache stopped answering", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hb559));
        rst <= 1'b1;
        mem_addr <= '0;
        mem_read <= 1'b0;
        mem_write <= 1'b0;
        mem_wdata <= '0;
        mem_byte_enable <= '0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[13'(a)] = fill_byte(13'(a));
            golden[13'(a)] = fill_byte(13'(a));
        end
        for (int s = 0; s < 8; s++) begin
            res_victim[3'(s)] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                res_valid[3'(s)][1'(w)] = 1'b0;
                res_dirty[3'(s)][1'(w)] = 1'b0;
                res_tag[3'(s)][1'(w)] = '0;
            end
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("mem_resp", mem_resp, 1'b0);
        check_flag("pmem_read", pmem_read, 1'b0);
        check_flag("pmem_write", pmem_write, 1'b0);

        // First read fills set 2, second read of that line hits
        cpu_access(1'b0, 32'h0000_0048, '0, '0);
        cpu_access(1'b0, 32'h0000_005c, '0, '0);
        // Byte-masked write hit and read back
        cpu_access(1'b1, 32'h0000_0044, 32'hdead_beef, 4'b0101);
        cpu_access(1'b0, 32'h0000_0044, '0, '0);
        // Set 3, third tag replaces the way not used last
        cpu_access(1'b0, 32'h0000_0060, '0, '0);
        cpu_access(1'b0, 32'h0000_0160, '0, '0);
        cpu_access(1'b0, 32'h0000_0064, '0, '0);
        cpu_access(1'b0, 32'h0000_0260, '0, '0);
        cpu_access(1'b0, 32'h0000_0068, '0, '0);
        cpu_access(1'b0, 32'h0000_0164, '0, '0);
        // Set 2, dirty line 0x040 goes back before the fill
        cpu_access(1'b0, 32'h0000_0140, '0, '0);
        cpu_access(1'b0, 32'h0000_0240, '0, '0);
        compare_image(32'h040, 32'h060);

        for (int i = 0; i < N_RANDOM; i++) begin
            cpu_access(1'($urandom % 2), cache_addr_t'($urandom % 4096) & 32'hffc,
                $urandom, 4'($urandom));
        end
        // Two fresh tags per set push every line out
        for (int s = 0; s < 8; s++) begin
            cpu_access(1'b0, 32'h1000 + 32'(s * 32), '0, '0);
            cpu_access(1'b0, 32'h1100 + 32'(s * 32), '0, '0);
        end
        compare_image(0, 4096);

        $display("errors: %0d word, %0d address, %0d flag, %0d other over %0d requests",
            word_errors, addr_errors, flag_errors, other_errors, issued);
        if (word_errors + addr_errors + flag_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+design
design/cache_pkg.sv
design/cache_control.sv
design/cache_tag_array.sv
design/cache_data_array.sv
design/cacheline_adapter.sv
design/cache.sv
test/cache_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module cache_tb -f files.f -o cache_sim

out=$(./obj_dir/cache_sim)
echo "$out"
echo "$out" | grep -q "TEST PASS"
